/* smartnic_host_stim.txt */
# kind then hex fields: R fn base num_q | W addr qid | H beats qid pattern last_keep
# P beats typ pattern last_keep | C beats hash pattern last_keep | G | B bp_en | T qid hash h2c_lat c2h_lat | F fail_cnt
R 0 000 010
R 1 100 020
R 2 110 040
R 3 800 800
W 5 0a5
B 0
T 005 5 3 1
H 3 005 a0000001 0f
H 1 115 a0000002 ff
H 2 130 a0000003 03
H 2 900 a0000004 01
H 2 300 a0000005 ff
H 1 fff a0000006 ff
G
F 1
B 1
H 4 00a b0000001 ff
H 2 400 b0000002 ff
H 3 11f b0000003 07
P 3 2 c0000001 1f
P 1 0 c0000002 ff
P 4 3 c0000003 3f
C 2 5 d0000001 ff
C 1 3 d0000002 0f
G
F 2
W 3 7f1
W 5 123
C 3 3 d0000003 ff
C 2 5 d0000004 ff
C 1 9 d0000005 ff
H 2 10f b0000004 ff
P 2 1 c0000004 ff
G
F 2

/* filelist.f */
smartnic_host_pkg.sv
axis_pipe.sv
host_q_classify.sv
axis_pkt_mux.sv
host_hash2qid.sv
smartnic_host.sv
tb_clk_gen.sv
smartnic_host_sva.sv
smartnic_host_tb.sv

/* Bender.yml */
package:
  name: smartnic_host

sources:
  - smartnic_host_pkg.sv
  - axis_pipe.sv
  - host_q_classify.sv
  - axis_pkt_mux.sv
  - host_hash2qid.sv
  - smartnic_host.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - smartnic_host_sva.sv
      - smartnic_host_tb.sv

/* smartnic_host_tb.sv */
`timescale 1ns/100ps

module smartnic_host_tb;

    import smartnic_host_pkg::*;

    localparam int TMO = 2000;

    // one queued packet with id as qid for host and hash for core
    typedef struct packed {
        logic [7:0]        nb;
        logic [QID_W-1:0]  id;
        logic [31:0]       pat;
        logic [KEEP_W-1:0] lkeep;
        logic [1:0]        typ;
    } pkt_t;

    logic core_clk, core_rstn;
    q_range_t q_range [NUM_FN];
    logic h2c_in_valid, h2c_in_ready, h2c_in_last;
    logic [DATA_W-1:0] h2c_in_data;
    logic [KEEP_W-1:0] h2c_in_keep;
    logic [QID_W-1:0] h2c_in_qid;
    logic pb_valid, pb_ready, pb_last;
    logic [DATA_W-1:0] pb_data;
    logic [KEEP_W-1:0] pb_keep;
    fn_typ_t pb_typ;
    logic h2c_out_valid, h2c_out_ready, h2c_out_last;
    logic [DATA_W-1:0] h2c_out_data;
    logic [KEEP_W-1:0] h2c_out_keep;
    fn_typ_t h2c_out_typ;
    logic [FAIL_CNT_W-1:0] q_fail_cnt;
    logic tbl_wr_en;
    logic [TBL_AW-1:0] tbl_wr_addr;
    logic [QID_W-1:0] tbl_wr_data;
    logic c2h_in_valid, c2h_in_ready, c2h_in_last;
    logic [DATA_W-1:0] c2h_in_data;
    logic [KEEP_W-1:0] c2h_in_keep;
    logic [HASH_W-1:0] c2h_in_hash;
    logic c2h_out_valid, c2h_out_ready, c2h_out_last;
    logic [DATA_W-1:0] c2h_out_data;
    logic [KEEP_W-1:0] c2h_out_keep;
    logic [QID_W-1:0] c2h_out_qid;

    h2c_beat_t host_exp[$];
    h2c_beat_t pb_exp[$];
    c2h_beat_t c2h_exp[$];
    pkt_t host_pend[$];
    pkt_t pb_pend[$];
    pkt_t core_pend[$];
    logic [QID_W-1:0] tbl_model [TBL_DEPTH];
    int errors = 0;
    int timeouts = 0;
    bit bp_en = 1'b0;
    bit h2c_sop = 1'b1;
    bit h2c_from_pb = 1'b0;

    tb_clk_gen u_clk (.core_clk (core_clk), .core_rstn (core_rstn));

    smartnic_host dut (.*);

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_h2c(input h2c_beat_t exp, input h2c_beat_t got);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] h2c_out beat: expected %h, got %h", exp, got);
        end
    endtask

    task automatic check_c2h(input c2h_beat_t exp, input c2h_beat_t got);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] c2h_out beat: expected %h, got %h", exp, got);
        end
    endtask

    task automatic check_cnt(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    // index of the lowest matching range or -1 for a drop
    function automatic int match_range(input logic [QID_W-1:0] qid);
        int r;
        r = -1;
        for (int i = NUM_FN - 1; i >= 0; i--) begin
            if (int'(qid) >= int'(q_range[i].base) &&
                int'(qid) < int'(q_range[i].base) + int'(q_range[i].num_q)) begin
                r = i;
            end
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] beat_data(input pkt_t p, input int b);
        return {p.pat, 32'(b)};
    endfunction

    function automatic logic [KEEP_W-1:0] beat_keep(input pkt_t p, input int b);
        return (b == p.nb - 1) ? p.lkeep : '1;
    endfunction

    function automatic logic port_ready(input int port);
        case (port)
            0: return h2c_in_ready;
            1: return pb_ready;
            default: return c2h_in_ready;
        endcase
    endfunction

    // ----------------------------------------
    // drivers
    // ----------------------------------------
    task automatic wait_ready(input int port);
        int n;
        n = 0;
        do begin
            @(negedge core_clk);
            n++;
        end while (!port_ready(port) && n < TMO);
        if (!port_ready(port)) note_timeout($sformatf("ready on input port %0d", port));
    endtask

    // port selects host (0) playback (1) or core (2)
    task automatic send_pkt(input int port, input pkt_t p);
        h2c_beat_t hb;
        c2h_beat_t cb;
        int ft;
        ft = match_range(p.id);
        for (int b = 0; b < p.nb; b++) begin
            hb = '{data: beat_data(p, b), keep: beat_keep(p, b), last: (b == p.nb - 1),
                   typ: fn_typ_t'((port == 1) ? p.typ : ft[1:0])};
            cb = '{data: beat_data(p, b), keep: beat_keep(p, b), last: (b == p.nb - 1),
                   qid: tbl_model[p.id[HASH_W-1:0]]};
            if (port == 0 && ft >= 0) host_exp.push_back(hb);
            if (port == 1) pb_exp.push_back(hb);
            if (port == 2) c2h_exp.push_back(cb);
        end
        @(posedge core_clk);
        for (int b = 0; b < p.nb; b++) begin
            case (port)
                0: begin
                    h2c_in_valid <= 1'b1;
                    h2c_in_data  <= beat_data(p, b);
                    h2c_in_keep  <= beat_keep(p, b);
                    h2c_in_last  <= (b == p.nb - 1);
                    h2c_in_qid   <= p.id;
                end
                1: begin
                    pb_valid <= 1'b1;
                    pb_data  <= beat_data(p, b);
                    pb_keep  <= beat_keep(p, b);
                    pb_last  <= (b == p.nb - 1);
                    pb_typ   <= fn_typ_t'(p.typ);
                end
                default: begin
                    c2h_in_valid <= 1'b1;
                    c2h_in_data  <= beat_data(p, b);
                    c2h_in_keep  <= beat_keep(p, b);
                    c2h_in_last  <= (b == p.nb - 1);
                    c2h_in_hash  <= p.id[HASH_W-1:0];
                end
            endcase
            wait_ready(port);
            @(posedge core_clk);
        end
        if (port == 0) h2c_in_valid <= 1'b0;
        if (port == 1) pb_valid <= 1'b0;
        if (port == 2) c2h_in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(negedge core_clk);
            n++;
        end while ((host_exp.size() + pb_exp.size() + c2h_exp.size()) != 0 && n < TMO);
        if ((host_exp.size() + pb_exp.size() + c2h_exp.size()) != 0) begin
            note_timeout("all expected beats to leave the DUT");
        end
    endtask

    // all three sources start together
    task automatic run_phase();
        fork
            while (host_pend.size() > 0) send_pkt(0, host_pend.pop_front());
            while (pb_pend.size() > 0) send_pkt(1, pb_pend.pop_front());
            while (core_pend.size() > 0) send_pkt(2, core_pend.pop_front());
        join
        wait_drain();
    endtask

    // cycles from an input transfer to the matching output valid
    task automatic time_path(input logic c2h, output logic [15:0] lat);
        int n;
        n = 0;
        do begin
            @(negedge core_clk);
            n++;
        end while (!(c2h ? (c2h_in_valid && c2h_in_ready) : (h2c_in_valid && h2c_in_ready))
                   && n < TMO);
        if (n >= TMO) note_timeout("input transfer in latency test");
        lat = '0;
        do begin
            @(negedge core_clk);
            lat++;
        end while (!(c2h ? c2h_out_valid : h2c_out_valid) && lat < TMO);
        if (lat >= TMO) note_timeout("output valid in latency test");
    endtask

    // ----------------------------------------
    // output side
    // ----------------------------------------
    // random stalls on both outputs once enabled
    initial begin : stall_gen
        void'($urandom(80));
        forever begin
            @(posedge core_clk);
            h2c_out_ready <= bp_en ? ($urandom_range(3) != 0) : 1'b1;
            c2h_out_ready <= bp_en ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    // source picked at sop by matching the host queue head
    always @(negedge core_clk) begin : h2c_monitor
        h2c_beat_t got;
        if (core_rstn && h2c_out_valid && h2c_out_ready) begin
            got = '{data: h2c_out_data, keep: h2c_out_keep, last: h2c_out_last, typ: h2c_out_typ};
            if (h2c_sop) h2c_from_pb = !(host_exp.size() > 0 && host_exp[0].data == got.data);
            h2c_sop = got.last;
            if (h2c_from_pb ? (pb_exp.size() == 0) : (host_exp.size() == 0)) begin
                errors++;
                $display("unexpected beat on h2c_out, data %h", got.data);
            end else if (h2c_from_pb) begin
                check_h2c(pb_exp.pop_front(), got);
            end else begin
                check_h2c(host_exp.pop_front(), got);
            end
        end
    end

    always @(negedge core_clk) begin : c2h_monitor
        c2h_beat_t got;
        if (core_rstn && c2h_out_valid && c2h_out_ready) begin
            got = '{data: c2h_out_data, keep: c2h_out_keep, last: c2h_out_last, qid: c2h_out_qid};
            if (c2h_exp.size() == 0) begin
                errors++;
                $display("unexpected beat on c2h_out, data %h", got.data);
            end else begin
                check_c2h(c2h_exp.pop_front(), got);
            end
        end
    end

    // ----------------------------------------
    // stimulus file
    // ----------------------------------------
    initial begin : main
        int fd;
        int n;
        string line;
        logic [7:0] kind;
        logic [31:0] a, b, c, d;
        logic [15:0] lat_h, lat_c;
        for (int i = 0; i < NUM_FN; i++) q_range[i] = '0;
        for (int i = 0; i < TBL_DEPTH; i++) tbl_model[i] = '0;
        h2c_in_valid = 1'b0;
        h2c_in_data = '0;
        h2c_in_keep = '0;
        h2c_in_last = 1'b0;
        h2c_in_qid = '0;
        pb_valid = 1'b0;
        pb_data = '0;
        pb_keep = '0;
        pb_last = 1'b0;
        pb_typ = PF;
        h2c_out_ready = 1'b1;
        tbl_wr_en = 1'b0;
        tbl_wr_addr = '0;
        tbl_wr_data = '0;
        c2h_in_valid = 1'b0;
        c2h_in_data = '0;
        c2h_in_keep = '0;
        c2h_in_last = 1'b0;
        c2h_in_hash = '0;
        c2h_out_ready = 1'b1;
        n = 0;
        do begin
            @(posedge core_clk);
            n++;
        end while (!core_rstn && n < TMO);
        if (!core_rstn) note_timeout("reset release");
        fd = $fopen("smartnic_host_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open smartnic_host_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                kind = 8'h00;
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                void'($sscanf(line, "%c %h %h %h %h", kind, a, b, c, d));
                case (kind)
                    "R": begin
                        @(posedge core_clk);
                        q_range[a] <= '{base: b[QID_W-1:0], num_q: c[QID_W:0]};
                    end
                    "W": begin
                        @(posedge core_clk);
                        tbl_wr_en   <= 1'b1;
                        tbl_wr_addr <= a[TBL_AW-1:0];
                        tbl_wr_data <= b[QID_W-1:0];
                        tbl_model[a[TBL_AW-1:0]] = b[QID_W-1:0];
                        @(posedge core_clk);
                        tbl_wr_en <= 1'b0;
                    end
                    "H": host_pend.push_back('{a[7:0], b[QID_W-1:0], c, d[KEEP_W-1:0], 2'd0});
                    "P": pb_pend.push_back('{a[7:0], '0, c, d[KEEP_W-1:0], b[1:0]});
                    "C": core_pend.push_back('{a[7:0], b[QID_W-1:0], c, d[KEEP_W-1:0], 2'd0});
                    "G": run_phase();
                    "B": begin
                        @(negedge core_clk);
                        bp_en = a[0];
                    end
                    "T": begin
                        fork
                            send_pkt(0, '{8'd1, a[QID_W-1:0], 32'h7e57_0001, 8'hff, 2'd0});
                            send_pkt(2, '{8'd1, b[QID_W-1:0], 32'h7e57_0002, 8'hff, 2'd0});
                            time_path(1'b0, lat_h);
                            time_path(1'b1, lat_c);
                        join
                        check_cnt("h2c latency", c[15:0], lat_h);
                        check_cnt("c2h latency", d[15:0], lat_c);
                        wait_drain();
                    end
                    "F": begin
                        @(negedge core_clk);
                        check_cnt("q_fail_cnt", a[15:0], q_fail_cnt);
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
        end
        // idle tail catches stray output beats
        repeat (8) @(negedge core_clk);
        $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, dut.u_sva.assert_fails);
        if (errors == 0 && timeouts == 0 && dut.u_sva.assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* smartnic_host_sva.sv */
`timescale 1ns/100ps

module smartnic_host_sva (
    input logic                                     core_clk,
    input logic                                     core_rstn,
    input logic                                     h2c_out_valid,
    input logic                                     h2c_out_ready,
    input logic [smartnic_host_pkg::DATA_W-1:0]     h2c_out_data,
    input logic [smartnic_host_pkg::KEEP_W-1:0]     h2c_out_keep,
    input logic                                     h2c_out_last,
    input smartnic_host_pkg::fn_typ_t               h2c_out_typ,
    input logic                                     c2h_out_valid,
    input logic                                     c2h_out_ready,
    input logic [smartnic_host_pkg::DATA_W-1:0]     c2h_out_data,
    input logic [smartnic_host_pkg::KEEP_W-1:0]     c2h_out_keep,
    input logic                                     c2h_out_last,
    input logic [smartnic_host_pkg::QID_W-1:0]      c2h_out_qid,
    input logic [smartnic_host_pkg::FAIL_CNT_W-1:0] q_fail_cnt
);

    int assert_fails = 0;

    // ----------------------------------------
    // stalled beats hold
    // ----------------------------------------
    h2c_hold: assert property (@(posedge core_clk) disable iff (!core_rstn)
        h2c_out_valid && !h2c_out_ready |=> h2c_out_valid &&
        $stable({h2c_out_data, h2c_out_keep, h2c_out_last, h2c_out_typ}))
        else begin
            $error("h2c_out beat changed while stalled");
            assert_fails++;
        end

    c2h_hold: assert property (@(posedge core_clk) disable iff (!core_rstn)
        c2h_out_valid && !c2h_out_ready |=> c2h_out_valid &&
        $stable({c2h_out_data, c2h_out_keep, c2h_out_last, c2h_out_qid}))
        else begin
            $error("c2h_out beat changed while stalled");
            assert_fails++;
        end

    // outputs quiet while in reset
    reset_quiet: assert property (@(posedge core_clk)
        !core_rstn |=> !h2c_out_valid && !c2h_out_valid)
        else begin
            $error("output valid seen during reset");
            assert_fails++;
        end

    fail_cnt_mono: assert property (@(posedge core_clk) disable iff (!core_rstn)
        q_fail_cnt >= $past(q_fail_cnt))
        else begin
            $error("q_fail_cnt went down");
            assert_fails++;
        end

endmodule

bind smartnic_host smartnic_host_sva u_sva (
    .core_clk      (core_clk),
    .core_rstn     (core_rstn),
    .h2c_out_valid (h2c_out_valid),
    .h2c_out_ready (h2c_out_ready),
    .h2c_out_data  (h2c_out_data),
    .h2c_out_keep  (h2c_out_keep),
    .h2c_out_last  (h2c_out_last),
    .h2c_out_typ   (h2c_out_typ),
    .c2h_out_valid (c2h_out_valid),
    .c2h_out_ready (c2h_out_ready),
    .c2h_out_data  (c2h_out_data),
    .c2h_out_keep  (c2h_out_keep),
    .c2h_out_last  (c2h_out_last),
    .c2h_out_qid   (c2h_out_qid),
    .q_fail_cnt    (q_fail_cnt)
);

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic core_clk,
    output logic core_rstn
);

    // 40 ns period
    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    // reset low for 16 rising edges, released on an edge
    initial begin
        core_rstn = 1'b0;
        repeat (16) @(posedge core_clk);
        core_rstn <= 1'b1;
    end

endmodule

/* smartnic_host.sv */
`timescale 1ns/100ps

module smartnic_host (
    input  logic                                     core_clk,
    input  logic                                     core_rstn,

    input  smartnic_host_pkg::q_range_t              q_range [smartnic_host_pkg::NUM_FN],

    input  logic                                     h2c_in_valid,
    output logic                                     h2c_in_ready,
    input  logic [smartnic_host_pkg::DATA_W-1:0]     h2c_in_data,
    input  logic [smartnic_host_pkg::KEEP_W-1:0]     h2c_in_keep,
    input  logic                                     h2c_in_last,
    input  logic [smartnic_host_pkg::QID_W-1:0]      h2c_in_qid,

    input  logic                                     pb_valid,
    output logic                                     pb_ready,
    input  logic [smartnic_host_pkg::DATA_W-1:0]     pb_data,
    input  logic [smartnic_host_pkg::KEEP_W-1:0]     pb_keep,
    input  logic                                     pb_last,
    input  smartnic_host_pkg::fn_typ_t               pb_typ,

    output logic                                     h2c_out_valid,
    input  logic                                     h2c_out_ready,
    output logic [smartnic_host_pkg::DATA_W-1:0]     h2c_out_data,
    output logic [smartnic_host_pkg::KEEP_W-1:0]     h2c_out_keep,
    output logic                                     h2c_out_last,
    output smartnic_host_pkg::fn_typ_t               h2c_out_typ,

    output logic [smartnic_host_pkg::FAIL_CNT_W-1:0] q_fail_cnt,

    input  logic                                     tbl_wr_en,
    input  logic [smartnic_host_pkg::TBL_AW-1:0]     tbl_wr_addr,
    input  logic [smartnic_host_pkg::QID_W-1:0]      tbl_wr_data,

    input  logic                                     c2h_in_valid,
    output logic                                     c2h_in_ready,
    input  logic [smartnic_host_pkg::DATA_W-1:0]     c2h_in_data,
    input  logic [smartnic_host_pkg::KEEP_W-1:0]     c2h_in_keep,
    input  logic                                     c2h_in_last,
    input  logic [smartnic_host_pkg::HASH_W-1:0]     c2h_in_hash,

    output logic                                     c2h_out_valid,
    input  logic                                     c2h_out_ready,
    output logic [smartnic_host_pkg::DATA_W-1:0]     c2h_out_data,
    output logic [smartnic_host_pkg::KEEP_W-1:0]     c2h_out_keep,
    output logic                                     c2h_out_last,
    output logic [smartnic_host_pkg::QID_W-1:0]      c2h_out_qid
);

    import smartnic_host_pkg::*;

    logic      cls_valid, cls_ready;
    h2c_beat_t cls_beat;
    logic      hp_valid, hp_ready;
    h2c_beat_t hp_beat;
    h2c_beat_t pb_beat;
    logic      mux_valid, mux_ready;
    h2c_beat_t mux_beat;
    h2c_beat_t out_beat;
    c2h_beat_t c2h_beat;

    // ----------------------------------------
    // host to core
    // ----------------------------------------
    host_q_classify u_classify (
        .core_clk (core_clk), .core_rstn (core_rstn), .q_range (q_range),
        .in_valid (h2c_in_valid), .in_ready (h2c_in_ready), .in_data (h2c_in_data),
        .in_keep (h2c_in_keep), .in_last (h2c_in_last), .in_qid (h2c_in_qid),
        .out_valid (cls_valid), .out_ready (cls_ready), .out_beat (cls_beat),
        .q_fail_cnt (q_fail_cnt)
    );

    axis_pipe #(.payload_t(h2c_beat_t)) u_host_pipe (
        .core_clk (core_clk), .core_rstn (core_rstn),
        .in_valid (cls_valid), .in_ready (cls_ready), .in_beat (cls_beat),
        .out_valid (hp_valid), .out_ready (hp_ready), .out_beat (hp_beat)
    );

    // playback fields already carry their type
    assign pb_beat = '{data: pb_data, keep: pb_keep, last: pb_last, typ: pb_typ};

    axis_pkt_mux u_mux (
        .core_clk (core_clk), .core_rstn (core_rstn),
        .in0_valid (hp_valid), .in0_ready (hp_ready), .in0_beat (hp_beat),
        .in1_valid (pb_valid), .in1_ready (pb_ready), .in1_beat (pb_beat),
        .out_valid (mux_valid), .out_ready (mux_ready), .out_beat (mux_beat)
    );

    axis_pipe #(.payload_t(h2c_beat_t)) u_out_pipe (
        .core_clk (core_clk), .core_rstn (core_rstn),
        .in_valid (mux_valid), .in_ready (mux_ready), .in_beat (mux_beat),
        .out_valid (h2c_out_valid), .out_ready (h2c_out_ready), .out_beat (out_beat)
    );

    assign h2c_out_data = out_beat.data;
    assign h2c_out_keep = out_beat.keep;
    assign h2c_out_last = out_beat.last;
    assign h2c_out_typ  = out_beat.typ;

    // ----------------------------------------
    // core to host
    // ----------------------------------------
    host_hash2qid u_hash2qid (
        .core_clk (core_clk), .core_rstn (core_rstn),
        .tbl_wr_en (tbl_wr_en), .tbl_wr_addr (tbl_wr_addr), .tbl_wr_data (tbl_wr_data),
        .in_valid (c2h_in_valid), .in_ready (c2h_in_ready), .in_data (c2h_in_data),
        .in_keep (c2h_in_keep), .in_last (c2h_in_last), .in_hash (c2h_in_hash),
        .out_valid (c2h_out_valid), .out_ready (c2h_out_ready), .out_beat (c2h_beat)
    );

    assign c2h_out_data = c2h_beat.data;
    assign c2h_out_keep = c2h_beat.keep;
    assign c2h_out_last = c2h_beat.last;
    assign c2h_out_qid  = c2h_beat.qid;

endmodule

/* host_hash2qid.sv */
`timescale 1ns/100ps

module host_hash2qid (
    input  logic                                   core_clk,
    input  logic                                   core_rstn,

    input  logic                                   tbl_wr_en,
    input  logic [smartnic_host_pkg::TBL_AW-1:0]   tbl_wr_addr,
    input  logic [smartnic_host_pkg::QID_W-1:0]    tbl_wr_data,

    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic [smartnic_host_pkg::DATA_W-1:0]   in_data,
    input  logic [smartnic_host_pkg::KEEP_W-1:0]   in_keep,
    input  logic                                   in_last,
    input  logic [smartnic_host_pkg::HASH_W-1:0]   in_hash,

    output logic                                   out_valid,
    input  logic                                   out_ready,
    output smartnic_host_pkg::c2h_beat_t           out_beat
);

    import smartnic_host_pkg::*;

    logic [QID_W-1:0] tbl [TBL_DEPTH];
    c2h_beat_t        lk_beat;

    // ----------------------------------------
    // hash to qid table
    // ----------------------------------------
    // cleared on reset, unwritten entries read as queue 0
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            for (int i = 0; i < TBL_DEPTH; i++) begin
                tbl[i] <= '0;
            end
        end else if (tbl_wr_en) begin
            tbl[tbl_wr_addr] <= tbl_wr_data;
        end
    end

    // lookup in the transfer cycle, a same-cycle write is not seen
    assign lk_beat = '{data: in_data, keep: in_keep, last: in_last, qid: tbl[in_hash]};

    // register stage for latency and back-pressure
    axis_pipe #(
        .payload_t (c2h_beat_t)
    ) u_out_pipe (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (lk_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

endmodule

/* axis_pkt_mux.sv */
`timescale 1ns/100ps

module axis_pkt_mux (
    input  logic                         core_clk,
    input  logic                         core_rstn,

    input  logic                         in0_valid,
    output logic                         in0_ready,
    input  smartnic_host_pkg::h2c_beat_t in0_beat,

    input  logic                         in1_valid,
    output logic                         in1_ready,
    input  smartnic_host_pkg::h2c_beat_t in1_beat,

    output logic                         out_valid,
    input  logic                         out_ready,
    output smartnic_host_pkg::h2c_beat_t out_beat
);

    // grant holds the locked input while busy, else the preferred one
    logic grant;
    logic busy;
    logic sel;

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    always_comb begin
        if (busy || (in0_valid && in1_valid)) begin
            sel = grant;
        end else begin
            // only one or no requester
            sel = in1_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            grant <= 1'b0;
            busy  <= 1'b0;
        end else if (out_valid) begin
            if (out_ready) begin
                // end of packet hands preference to the other side
                busy  <= !out_beat.last;
                grant <= out_beat.last ? ~sel : sel;
            end else begin
                // stalled beat keeps the same source until it goes
                busy  <= 1'b1;
                grant <= sel;
            end
        end
    end

    // ----------------------------------------
    // data path
    // ----------------------------------------
    assign out_valid = sel ? in1_valid : in0_valid;
    assign out_beat  = sel ? in1_beat : in0_beat;
    assign in0_ready = out_ready && !sel;
    assign in1_ready = out_ready && sel;

endmodule

/* host_q_classify.sv */
`timescale 1ns/100ps

module host_q_classify (
    input  logic                                       core_clk,
    input  logic                                       core_rstn,

    input  smartnic_host_pkg::q_range_t                q_range [smartnic_host_pkg::NUM_FN],

    input  logic                                       in_valid,
    output logic                                       in_ready,
    input  logic [smartnic_host_pkg::DATA_W-1:0]       in_data,
    input  logic [smartnic_host_pkg::KEEP_W-1:0]       in_keep,
    input  logic                                       in_last,
    input  logic [smartnic_host_pkg::QID_W-1:0]        in_qid,

    output logic                                       out_valid,
    input  logic                                       out_ready,
    output smartnic_host_pkg::h2c_beat_t               out_beat,

    output logic [smartnic_host_pkg::FAIL_CNT_W-1:0]   q_fail_cnt
);

    import smartnic_host_pkg::*;

    logic              in_sop;
    logic              pkt_pass;
    fn_typ_t           pkt_typ;
    logic [NUM_FN-1:0] hit;
    fn_typ_t           enc_typ;
    logic              cur_pass;
    fn_typ_t           cur_typ;
    logic              in_xfer;

    // ----------------------------------------
    // range match and type select
    // ----------------------------------------
    // 14-bit compare, base + num_q can exceed 13 bits
    always_comb begin
        for (int i = 0; i < NUM_FN; i++) begin
            hit[i] = ({2'b00, in_qid} >= {2'b00, q_range[i].base}) &&
                     ({2'b00, in_qid} < ({2'b00, q_range[i].base} + {1'b0, q_range[i].num_q}));
        end
    end

    // lowest matching range wins
    always_comb begin
        enc_typ = PF;
        for (int i = NUM_FN - 1; i >= 0; i--) begin
            if (hit[i]) begin
                enc_typ = fn_typ_t'(2'(i));
            end
        end
    end

    // decision taken at sop, held until last
    assign cur_pass = in_sop ? |hit : pkt_pass;
    assign cur_typ  = in_sop ? enc_typ : pkt_typ;

    // failing beats are swallowed without waiting on the output
    assign in_ready = !cur_pass || !out_valid || out_ready;
    assign in_xfer  = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            in_sop   <= 1'b1;
            pkt_pass <= 1'b0;
            pkt_typ  <= PF;
        end else if (in_xfer) begin
            in_sop   <= in_last;
            pkt_pass <= cur_pass;
            pkt_typ  <= cur_typ;
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_valid <= 1'b0;
        end else if (!out_valid || out_ready) begin
            out_valid <= in_valid && cur_pass;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_xfer && cur_pass) begin
            out_beat <= '{data: in_data, keep: in_keep, last: in_last, typ: cur_typ};
        end
    end

    // one count per dropped packet, saturating
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            q_fail_cnt <= '0;
        end else if (in_xfer && in_sop && !(|hit) && (q_fail_cnt != '1)) begin
            q_fail_cnt <= q_fail_cnt + 1'b1;
        end
    end

endmodule

/* axis_pipe.sv */
`timescale 1ns/100ps

module axis_pipe #(
    parameter type payload_t = smartnic_host_pkg::h2c_beat_t
) (
    input  logic     core_clk,
    input  logic     core_rstn,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_beat,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_beat
);

    // ----------------------------------------
    // single entry register slice
    // ----------------------------------------
    // accept when empty or when the held beat leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on an input transfer
    always_ff @(posedge core_clk) begin
        if (in_valid && in_ready) begin
            out_beat <= in_beat;
        end
    end

endmodule

/* smartnic_host_pkg.sv */
package smartnic_host_pkg;

    // ----------------------------------------
    // stream and table dimensions
    // ----------------------------------------
    localparam int DATA_W     = 64;
    localparam int KEEP_W     = 8;
    localparam int QID_W      = 12;
    localparam int HASH_W     = 4;
    localparam int NUM_FN     = 4;
    localparam int TBL_DEPTH  = 16;
    localparam int TBL_AW     = $clog2(TBL_DEPTH);
    localparam int FAIL_CNT_W = 16;

    // ----------------------------------------
    // host function types
    // ----------------------------------------
    // range index i maps to type i, so lower type means higher priority
    typedef enum logic [1:0] {
        PF  = 2'd0,
        VF0 = 2'd1,
        VF1 = 2'd2,
        VF2 = 2'd3
    } fn_typ_t;

    // queue range, qid in [base, base + num_q)
    // num_q is one bit wider so a range can cover all 4096 queues
    typedef struct packed {
        logic [QID_W-1:0] base;
        logic [QID_W:0]   num_q;
    } q_range_t;

    // ----------------------------------------
    // beat payloads
    // ----------------------------------------
    // host to core, tagged with function type
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        fn_typ_t           typ;
    } h2c_beat_t;

    // core to host, hash already replaced by queue id
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic [QID_W-1:0]  qid;
    } c2h_beat_t;

endpackage
